//--- include/amtz_defs.svh
`ifndef AMTZ_DEFS_SVH
`define AMTZ_DEFS_SVH

// count of micro-operation strobes driven each cycle
// strobe n sits at bit n-1 of the vector
`define AMTZ_UOP_W 52

// width of the state encoding
`define AMTZ_STATE_W 5

`endif

//--- source/amtz_pkg.sv
`default_nettype none

`include "amtz_defs.svh"

package amtz_pkg;

	//////////////////////////////
	// states
	//////////////////////////////

	// the number in each name is the state it stands for in the full sequence
	typedef enum logic [`AMTZ_STATE_W-1:0] {
		st_idle,
		st_a2, st_a4, st_a6, st_a8, st_a10, st_a12, st_a14, st_a16, st_a18,
		st_b3, st_b5, st_b7, st_b9, st_b11, st_b13, st_b15,
		st_dispatch,
		st_finish,
		st_retry
	} amtz_state_e;

	//////////////////////////////
	// micro words
	//////////////////////////////

	// one opcode per distinct strobe set, the name lists the strobes
	typedef enum logic [5:0] {
		uw_none,
		uw_1_2_8, uw_17, uw_1_2_7_19, uw_5, uw_1_19_20_21, uw_13, uw_2_4_20, uw_22,
		uw_1_2_7_8, uw_1_3_9_10_15, uw_1_9_11_12,
		uw_43, uw_1_2_11_16, uw_18,
		uw_25_26, uw_51_52, uw_1_20_47_48, uw_1_19_49_50, uw_10,
		uw_1_2_36, uw_42, uw_41, uw_40, uw_39, uw_1_2_11_36, uw_1_2_8_11, uw_46,
		uw_31_34_35, uw_30_32_33, uw_31, uw_30, uw_1_11_36_37_44,
		uw_1_2_8_27
	} uop_word_e;

	// condition inputs still sampled, numbering follows the full sequence
	typedef struct packed {
		logic x1;
		logic x2;
		logic x3;
		logic x4;
		logic x5;
		logic x6;
		logic x8;
		logic x9;
		logic x10;
		logic x15;
		logic x16;
		logic x17;
		logic x18;
		logic x21;
		logic x22;
		logic x23;
	} amtz_cond_t;

	typedef logic [`AMTZ_UOP_W-1:0] amtz_uop_t;

	typedef struct packed {
		amtz_state_e target;
		uop_word_e   word;
	} dispatch_t;

	// finish rule, strobe 43 only when x21 is up together with x16 or x15
	function automatic uop_word_e finish_word(input amtz_cond_t c);
		if (c.x21 && (c.x16 || c.x15))
			return uw_43;
		return uw_none;
	endfunction

endpackage

`default_nettype wire

//--- source/amtz_uop_encoder.sv
`default_nettype none

module amtz_uop_encoder (
	input  amtz_pkg::uop_word_e word,
	output amtz_pkg::amtz_uop_t uop
);
	import amtz_pkg::*;

	// one-hot vector for strobe n
	function automatic amtz_uop_t strobe(input int unsigned n);
		return amtz_uop_t'(1) << (n - 1);
	endfunction

	always_comb
	begin
		case (word)
			uw_1_2_8: uop = strobe(1) | strobe(2) | strobe(8);
			uw_17: uop = strobe(17);
			uw_1_2_7_19: uop = strobe(1) | strobe(2) | strobe(7) | strobe(19);
			uw_5: uop = strobe(5);
			uw_1_19_20_21: uop = strobe(1) | strobe(19) | strobe(20) | strobe(21);
			uw_13: uop = strobe(13);
			uw_2_4_20: uop = strobe(2) | strobe(4) | strobe(20);
			uw_22: uop = strobe(22);
			uw_1_2_7_8: uop = strobe(1) | strobe(2) | strobe(7) | strobe(8);
			uw_1_3_9_10_15: uop = strobe(1) | strobe(3) | strobe(9) | strobe(10) | strobe(15);
			uw_1_9_11_12: uop = strobe(1) | strobe(9) | strobe(11) | strobe(12);
			uw_43: uop = strobe(43);
			uw_1_2_11_16: uop = strobe(1) | strobe(2) | strobe(11) | strobe(16);
			uw_18: uop = strobe(18);
			uw_25_26: uop = strobe(25) | strobe(26);
			uw_51_52: uop = strobe(51) | strobe(52);
			uw_1_20_47_48: uop = strobe(1) | strobe(20) | strobe(47) | strobe(48);
			uw_1_19_49_50: uop = strobe(1) | strobe(19) | strobe(49) | strobe(50);
			uw_10: uop = strobe(10);
			uw_1_2_36: uop = strobe(1) | strobe(2) | strobe(36);
			uw_42: uop = strobe(42);
			uw_41: uop = strobe(41);
			uw_40: uop = strobe(40);
			uw_39: uop = strobe(39);
			uw_1_2_11_36: uop = strobe(1) | strobe(2) | strobe(11) | strobe(36);
			uw_1_2_8_11: uop = strobe(1) | strobe(2) | strobe(8) | strobe(11);
			uw_46: uop = strobe(46);
			uw_31_34_35: uop = strobe(31) | strobe(34) | strobe(35);
			uw_30_32_33: uop = strobe(30) | strobe(32) | strobe(33);
			uw_31: uop = strobe(31);
			uw_30: uop = strobe(30);
			uw_1_11_36_37_44: uop = strobe(1) | strobe(11) | strobe(36) | strobe(37) | strobe(44);
			uw_1_2_8_27: uop = strobe(1) | strobe(2) | strobe(8) | strobe(27);
			default: uop = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/amtz_dispatch.sv
`default_nettype none

module amtz_dispatch (
	input  amtz_pkg::amtz_cond_t  cond,
	input  amtz_pkg::amtz_state_e state,
	output amtz_pkg::dispatch_t   route
);
	import amtz_pkg::*;

	logic in_retry;

	// the retry state swaps the not-x3 leaves for a single strobe set
	assign in_retry = (state == st_retry);

	//////////////////////////////
	// mode tree
	//////////////////////////////

	// most leaves go on to the finish state, so that is the starting point
	always_comb
	begin
		route = '{st_finish, uw_none};
		case ({cond.x22, cond.x23})
			2'b11:
			begin
				if (cond.x3 && cond.x4)
					route = '{st_idle, finish_word(cond)};
				else if (cond.x3)
					route = '{st_idle, cond.x5 ? uw_25_26 : uw_51_52};
				else if (!cond.x4)
					route.word = cond.x5 ? uw_1_20_47_48 : uw_1_19_49_50;
				else if (cond.x5 ? cond.x15 : cond.x16)
					route.word = uw_10;
				else
					route = '{st_idle, finish_word(cond)};
			end

			2'b10:
			begin
				if (cond.x9)
					route.word = uw_1_2_36;
				else if (cond.x3)
				begin
					case ({cond.x4, cond.x5})
						2'b11: route.word = uw_42;
						2'b10: route.word = uw_41;
						2'b01: route.word = uw_40;
						default: route.word = uw_39;
					endcase
				end
				else if (in_retry)
					route.word = uw_1_2_8_27;
				else if (cond.x8)
					route.word = uw_1_2_11_36;
				else
					route.word = uw_1_2_8_11;
			end

			2'b01:
			begin
				if (cond.x9)
					route.word = uw_46;
				else
					route.word = uw_1_2_8_11;
			end

			default:
			begin
				if (cond.x3)
				begin
					case ({cond.x4, cond.x5})
						2'b11: route.word = uw_31_34_35;
						2'b10: route.word = uw_30_32_33;
						2'b01: route.word = uw_31;
						default: route.word = uw_30;
					endcase
				end
				else if (in_retry)
					route.word = uw_1_2_8_27;
				else if (cond.x8)
					route.word = uw_1_11_36_37_44;
				else
					route.word = uw_1_2_8_11;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/amtz_sequencer.sv
`default_nettype none

module amtz_sequencer (
	input  logic                  rst,
	input  logic                  clk,
	input  amtz_pkg::amtz_cond_t  cond,
	input  amtz_pkg::dispatch_t   route,
	output amtz_pkg::amtz_state_e state,
	output amtz_pkg::uop_word_e   word
);
	import amtz_pkg::*;

	dispatch_t step;

	//////////////////////////////
	// state register
	//////////////////////////////

	// the state moves on the rising edge of rst while clk low holds it in idle
	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= st_idle;
		else
			state <= step.target;
	end

	// a start request cannot raise strobes while clk holds the reset
	assign word = clk ? step.word : uw_none;

	//////////////////////////////
	// transitions
	//////////////////////////////

	always_comb
	begin
		step = '{st_idle, uw_none};
		case (state)
			st_idle:
			begin
				if (cond.x1 && cond.x2)
					step = '{st_a2, uw_1_2_8};
				else if (cond.x1)
					step = '{st_b3, uw_17};
			end

			// path A has two loops that wait for x17
			st_a2: step = '{st_a4, uw_1_2_7_19};
			st_a4: step = '{st_a6, uw_5};
			st_a6: step = '{st_a8, uw_1_19_20_21};
			st_a8: step = '{st_a10, uw_13};
			st_a10:
			begin
				if (cond.x17)
					step = '{st_a12, uw_2_4_20};
				else
					step = '{st_a8, uw_1_19_20_21};
			end
			st_a12: step = '{st_a14, uw_5};
			st_a14: step = '{st_a16, uw_1_19_20_21};
			st_a16: step = '{st_a18, uw_13};
			st_a18:
			begin
				if (cond.x17)
					step = '{st_finish, uw_22};
				else
					step = '{st_a16, uw_1_19_20_21};
			end

			// path B has one wait loop before the mode dispatch
			st_b3: step = '{st_b5, uw_1_2_7_8};
			st_b5: step = '{st_b7, uw_1_3_9_10_15};
			st_b7: step = '{st_b9, uw_1_2_7_8};
			st_b9: step = '{st_b11, uw_5};
			st_b11: step = '{st_b13, uw_1_9_11_12};
			st_b13: step = '{st_b15, uw_13};
			st_b15:
			begin
				if (cond.x17)
					step = '{st_dispatch, uw_1_3_9_10_15};
				else
					step = '{st_b13, uw_1_9_11_12};
			end

			// without x18 the mode tree is skipped and the retry state decides
			st_dispatch:
			begin
				if (!cond.x18)
					step = '{st_retry, uw_1_2_11_16};
				else
					step = route;
			end
			st_retry:
			begin
				if (cond.x6)
					step = '{st_b3, uw_18};
				else
					step = route;
			end

			st_finish: step = '{st_idle, finish_word(cond)};

			default: step = '{st_idle, uw_none};
		endcase
	end

endmodule

`default_nettype wire

//--- source/amtz_ctrl.sv
`default_nettype none

module amtz_ctrl (
	input  logic                 rst,
	input  logic                 clk,
	input  amtz_pkg::amtz_cond_t cond,
	output amtz_pkg::amtz_uop_t  uop
);
	import amtz_pkg::*;

	amtz_state_e state;
	uop_word_e   word;
	dispatch_t   route;

	amtz_sequencer i_amtz_sequencer (
		.rst   (rst),
		.clk   (clk),
		.cond  (cond),
		.route (route),
		.state (state),
		.word  (word)
	);

	amtz_dispatch i_amtz_dispatch (
		.cond  (cond),
		.state (state),
		.route (route)
	);

	amtz_uop_encoder i_amtz_uop_encoder (
		.word (word),
		.uop  (uop)
	);

endmodule

`default_nettype wire

//--- tb/amtz_ctrl_assert.sv
`default_nettype none

module amtz_ctrl_assert (
	input logic                 rst,
	input logic                 clk,
	input amtz_pkg::amtz_cond_t cond,
	input amtz_pkg::amtz_uop_t  uop
);
	timeunit 1ns;
	timeprecision 100ps;

	quiet_in_reset: assert property (@(posedge rst) !clk |-> uop == '0)
		else $error("uop is not zero while reset is held");

	// strobe 43 sits at bit 42, strobes 17 and 18 at bits 16 and 17
	finish_needs_x21: assert property (@(posedge rst) disable iff (!clk)
		uop[42] |-> cond.x21)
		else $error("strobe 43 is set while x21 is low");

	no_start_with_finish: assert property (@(posedge rst) disable iff (!clk)
		uop[42] |-> !(uop[16] || uop[17]))
		else $error("strobe 17 or 18 is set together with strobe 43");

endmodule

bind amtz_ctrl amtz_ctrl_assert i_amtz_ctrl_assert (
	.rst  (rst),
	.clk  (clk),
	.cond (cond),
	.uop  (uop)
);

`default_nettype wire

//--- tb/amtz_clock_gen.sv
`default_nettype none

module amtz_clock_gen (
	output logic rst,
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// rst is the 4 ns clock, clk is the active low reset
	initial
	begin
		rst = 1'b0;
		forever
			#2 rst = ~rst;
	end

	initial
	begin
		clk = 1'b0;
		repeat (10)
			@(posedge rst);
		clk <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/amtz_ctrl_tb.sv
`default_nettype none

module amtz_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import amtz_pkg::*;

	// the worst case is about 220 cycles because the leaf test alone walks path B four times
	localparam int max_cycles = 400;

	logic rst;
	logic clk;
	amtz_cond_t cond;
	amtz_uop_t uop;
	string test_name;
	int cycles;
	int checks;
	int errors;
	int test_errors;
	int tests;

	amtz_clock_gen i_amtz_clock_gen (.rst(rst), .clk(clk));
	amtz_ctrl i_amtz_ctrl (.rst(rst), .clk(clk), .cond(cond), .uop(uop));

	function automatic amtz_uop_t strobe_set(input int a = 0, b = 0, c = 0, d = 0, e = 0);
		int list [5];
		amtz_uop_t v;
		list = '{a, b, c, d, e};
		v = '0;
		foreach (list[k])
			if (list[k] > 0)
				v = v | (amtz_uop_t'(1) << (list[k] - 1));
		return v;
	endfunction

	// condition xn is collected at bit n-1 and then picked in the field order of the struct
	function automatic amtz_cond_t cond_of(input int a = 0, b = 0, c = 0, d = 0, e = 0);
		amtz_uop_t x;
		x = strobe_set(a, b, c, d, e);
		return amtz_cond_t'({x[0], x[1], x[2], x[3], x[4], x[5], x[7], x[8],
			x[9], x[14], x[15], x[16], x[17], x[20], x[21], x[22]});
	endfunction

	// cond changes on the rising edge and uop is compared at the falling edge
	task automatic apply(input amtz_cond_t c, input amtz_uop_t expected);
		@(posedge rst);
		cond <= c;
		@(negedge rst);
		checks++;
		assert (uop === expected)
		else
		begin
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, uop);
			errors++;
			test_errors++;
		end
	endtask

	task automatic wait_loop(input amtz_uop_t spin, input amtz_uop_t leave);
		repeat (1 + $urandom % 4)
		begin
			apply(cond_of(), strobe_set(13));
			apply(cond_of(), spin);
		end
		apply(cond_of(), strobe_set(13));
		apply(cond_of(17), leave);
	endtask

	// walks path B up to the dispatch state from idle or from the retry exit
	task automatic walk_b(input bit from_idle);
		if (from_idle)
			apply(cond_of(1), strobe_set(17));
		apply(cond_of(), strobe_set(1, 2, 7, 8));
		apply(cond_of(), strobe_set(1, 3, 9, 10, 15));
		apply(cond_of(), strobe_set(1, 2, 7, 8));
		apply(cond_of(), strobe_set(5));
		apply(cond_of(), strobe_set(1, 9, 11, 12));
		wait_loop(strobe_set(1, 9, 11, 12), strobe_set(1, 3, 9, 10, 15));
	endtask

	// takes a dispatch leaf into the finish state and spends one cycle back in idle
	task automatic finish_leaf(input amtz_cond_t c, input amtz_uop_t expected,
		input amtz_cond_t fin, input amtz_uop_t fin_expected);
		walk_b(1'b1);
		apply(c, expected);
		apply(fin, fin_expected);
		apply(cond_of(), '0);
	endtask

	task automatic report();
		tests++;
		$display("test %s finished with %0d errors", test_name, test_errors);
		test_errors = 0;
	endtask

	task automatic idle_after_reset();
		test_name = "idle_after_reset";
		repeat (5)
			apply(cond_of(), '0);
		report();
	endtask

	task automatic path_a();
		test_name = "path_a";
		apply(cond_of(1, 2), strobe_set(1, 2, 8));
		apply(cond_of(), strobe_set(1, 2, 7, 19));
		apply(cond_of(), strobe_set(5));
		apply(cond_of(), strobe_set(1, 19, 20, 21));
		wait_loop(strobe_set(1, 19, 20, 21), strobe_set(2, 4, 20));
		apply(cond_of(), strobe_set(5));
		apply(cond_of(), strobe_set(1, 19, 20, 21));
		wait_loop(strobe_set(1, 19, 20, 21), strobe_set(22));
		apply(cond_of(21, 15), strobe_set(43));
		apply(cond_of(), '0);
		report();
	endtask

	task automatic path_b_dispatch();
		test_name = "path_b_dispatch";
		walk_b(1'b1);
		apply(cond_of(18, 22, 23, 3, 5), strobe_set(25, 26));
		apply(cond_of(), '0);
		report();
	endtask

	task automatic finish_rule();
		test_name = "finish_rule";
		finish_leaf(cond_of(18, 22, 9), strobe_set(1, 2, 36), cond_of(21, 16), strobe_set(43));
		finish_leaf(cond_of(18, 22, 9), strobe_set(1, 2, 36), cond_of(16), '0);
		report();
	endtask

	task automatic retry();
		test_name = "retry";
		walk_b(1'b1);
		apply(cond_of(), strobe_set(1, 2, 11, 16));
		apply(cond_of(6), strobe_set(18));
		walk_b(1'b0);
		apply(cond_of(18, 22, 23, 3, 5), strobe_set(25, 26));
		report();
	endtask

	task automatic dispatch_leaves();
		test_name = "dispatch_leaves";
		finish_leaf(cond_of(18, 22, 3, 4, 5), strobe_set(42), cond_of(), '0);
		finish_leaf(cond_of(18, 3, 4, 5), strobe_set(31, 34, 35), cond_of(), '0);
		finish_leaf(cond_of(18, 23, 9), strobe_set(46), cond_of(), '0);
		walk_b(1'b1);
		apply(cond_of(), strobe_set(1, 2, 11, 16));
		apply(cond_of(22), strobe_set(1, 2, 8, 27));
		apply(cond_of(), '0);
		report();
	endtask

	always @(posedge rst)
	begin
		cycles++;
		if (cycles > max_cycles)
		begin
			$display("timeout, the tests did not end within %0d cycles", max_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial
	begin
		// a start request held during reset must leave uop at zero
		cond = cond_of(1, 2);
		void'($urandom(32'h451a));
		@(posedge clk);
		cond <= '0;
		idle_after_reset();
		path_a();
		path_b_dispatch();
		finish_rule();
		retry();
		dispatch_leaves();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
source/amtz_pkg.sv
source/amtz_uop_encoder.sv
source/amtz_dispatch.sv
source/amtz_sequencer.sv
source/amtz_ctrl.sv
tb/amtz_ctrl_assert.sv
tb/amtz_clock_gen.sv
tb/amtz_ctrl_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module amtz_ctrl_tb

./obj_dir/Vamtz_ctrl_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log
then
	exit 0
fi
exit 1
